// ==== source/ternary_cfg.svh ====
// Word and opcode sizes of the ternary ALU, included by the package and the RTL modules
`ifndef TERNARY_CFG_SVH
`define TERNARY_CFG_SVH

// Trits in one data word, two bits per trit
`define WORD_TRITS 9

// Trits in one opcode
`define OPCODE_TRITS 3

`endif

// ==== source/ternary_pkg.sv ====
// Shared trit, word, opcode and select types of the ternary ALU, imported by every module
`include "ternary_cfg.svh"

package ternary_pkg;

    // One balanced-ternary trit, 2-bit two's complement style code
    typedef logic [1:0] trit_t;

    // Trit 0 sits in bits [1:0]
    typedef logic [2*`WORD_TRITS-1:0] word_t;

    localparam trit_t TRIT_ZERO = 2'b00;
    localparam trit_t TRIT_POS  = 2'b01;
    localparam trit_t TRIT_NEG  = 2'b11;

    // Opcodes written as three trits, top trit first
    typedef enum logic [2*`OPCODE_TRITS-1:0] {
        OP_NOT  = 6'b00_00_01,
        OP_AND  = 6'b00_01_00,
        OP_ANDI = 6'b00_01_01,
        OP_OR   = 6'b00_01_11,
        OP_XOR  = 6'b00_11_00,
        OP_ADD  = 6'b01_00_00,
        OP_ADDI = 6'b01_00_01,
        OP_SUB  = 6'b01_00_11,
        OP_COMP = 6'b01_01_00,
        OP_LT   = 6'b01_01_01,
        OP_EQ   = 6'b01_01_11
    } opcode_t;

    typedef enum logic [1:0] {
        FN_NOT,
        FN_AND,
        FN_OR,
        FN_XOR
    } logic_fn_t;

    typedef enum logic [2:0] {
        SRC_LOGIC,
        SRC_ARITH,
        SRC_LT,
        SRC_EQ,
        SRC_PASS
    } res_src_t;

    // Trit negation, shared by the NOT table and the subtract path
    function automatic trit_t trit_neg(trit_t t);
        case (t)
            TRIT_POS: return TRIT_NEG;
            TRIT_NEG: return TRIT_POS;
            default:  return TRIT_ZERO;
        endcase
    endfunction

endpackage

// ==== source/alu_decode.sv ====
// Opcode decoder of the ternary ALU, gives the logic function, subtract and result selects
module alu_decode (
    input  ternary_pkg::opcode_t   opcode,
    input  logic                   alu_enable,
    output ternary_pkg::logic_fn_t logic_fn,
    output logic                   sub,
    output ternary_pkg::res_src_t  res_src,
    output logic                   load
);
    import ternary_pkg::*;

    always_comb begin
        logic_fn = FN_NOT;
        sub      = 1'b0;
        res_src  = SRC_PASS;
        case (opcode)
            OP_NOT: begin
                logic_fn = FN_NOT;
                res_src  = SRC_LOGIC;
            end
            // ANDI shares the AND path
            OP_AND, OP_ANDI: begin
                logic_fn = FN_AND;
                res_src  = SRC_LOGIC;
            end
            OP_OR: begin
                logic_fn = FN_OR;
                res_src  = SRC_LOGIC;
            end
            OP_XOR: begin
                logic_fn = FN_XOR;
                res_src  = SRC_LOGIC;
            end
            OP_ADD, OP_ADDI: begin
                res_src = SRC_ARITH;
            end
            OP_SUB: begin
                sub     = 1'b1;
                res_src = SRC_ARITH;
            end
            OP_LT:   res_src = SRC_LT;
            OP_EQ:   res_src = SRC_EQ;
            // COMP and unknown codes pass operand a through
            default: res_src = SRC_PASS;
        endcase
    end

    assign load = alu_enable;

endmodule

// ==== source/trit_logic_unit.sv ====
// Trit-wise NOT, AND, OR and XOR of two ternary words, selected by the decoder
`include "ternary_cfg.svh"

module trit_logic_unit (
    input  ternary_pkg::word_t     a,
    input  ternary_pkg::word_t     b,
    input  ternary_pkg::logic_fn_t logic_fn,
    output ternary_pkg::word_t     logic_result
);
    import ternary_pkg::*;

    // Minimum of two trits
    function automatic trit_t trit_and(trit_t x, trit_t y);
        case ({x, y})
            {TRIT_POS, TRIT_POS}: return TRIT_POS;
            {TRIT_NEG, TRIT_NEG}, {TRIT_NEG, TRIT_ZERO}, {TRIT_NEG, TRIT_POS},
            {TRIT_ZERO, TRIT_NEG}, {TRIT_POS, TRIT_NEG}: return TRIT_NEG;
            default: return TRIT_ZERO;
        endcase
    endfunction

    // Maximum of two trits
    function automatic trit_t trit_or(trit_t x, trit_t y);
        case ({x, y})
            {TRIT_NEG, TRIT_NEG}: return TRIT_NEG;
            {TRIT_POS, TRIT_POS}, {TRIT_POS, TRIT_ZERO}, {TRIT_POS, TRIT_NEG},
            {TRIT_ZERO, TRIT_POS}, {TRIT_NEG, TRIT_POS}: return TRIT_POS;
            default: return TRIT_ZERO;
        endcase
    endfunction

    // Zero passes the other trit, opposite signs cancel, equal non-zero gives -1
    function automatic trit_t trit_xor(trit_t x, trit_t y);
        case ({x, y})
            {TRIT_ZERO, TRIT_POS}, {TRIT_POS, TRIT_ZERO}: return TRIT_POS;
            {TRIT_ZERO, TRIT_NEG}, {TRIT_NEG, TRIT_ZERO},
            {TRIT_POS, TRIT_POS}, {TRIT_NEG, TRIT_NEG}: return TRIT_NEG;
            default: return TRIT_ZERO;
        endcase
    endfunction

    for (genvar i = 0; i < `WORD_TRITS; i++) begin : g_trit
        trit_t r;

        always_comb begin
            case (logic_fn)
                FN_NOT:  r = trit_neg(a[2*i +: 2]);
                FN_AND:  r = trit_and(a[2*i +: 2], b[2*i +: 2]);
                FN_OR:   r = trit_or(a[2*i +: 2], b[2*i +: 2]);
                default: r = trit_xor(a[2*i +: 2], b[2*i +: 2]);
            endcase
        end

        assign logic_result[2*i +: 2] = r;
    end

endmodule

// ==== source/ternary_adder.sv ====
// Balanced-ternary ripple adder of two words, subtracts by negating b, top carry dropped
`include "ternary_cfg.svh"

module ternary_adder (
    input  ternary_pkg::word_t a,
    input  ternary_pkg::word_t b,
    input  logic               sub,
    output ternary_pkg::word_t arith_result
);
    import ternary_pkg::*;

    // Sum and carry of three trits, returned as {carry, sum}
    function automatic logic [3:0] full_add(trit_t x, trit_t y, trit_t c);
        logic signed [2:0] total;
        // The trit code is a 2-bit signed value, so sign extension gives -1, 0 or +1
        total = $signed({x[1], x}) + $signed({y[1], y}) + $signed({c[1], c});
        case (total)
            -3:      return {TRIT_NEG, TRIT_ZERO};
            -2:      return {TRIT_NEG, TRIT_POS};
            -1:      return {TRIT_ZERO, TRIT_NEG};
            1:       return {TRIT_ZERO, TRIT_POS};
            2:       return {TRIT_POS, TRIT_NEG};
            3:       return {TRIT_POS, TRIT_ZERO};
            default: return {TRIT_ZERO, TRIT_ZERO};
        endcase
    endfunction

    always_comb begin
        trit_t carry;
        trit_t b_trit;
        trit_t sum_trit;
        carry = TRIT_ZERO;
        for (int i = 0; i < `WORD_TRITS; i++) begin
            b_trit = sub ? trit_neg(b[2*i +: 2]) : b[2*i +: 2];
            {carry, sum_trit} = full_add(a[2*i +: 2], b_trit, carry);
            arith_result[2*i +: 2] = sum_trit;
        end
    end

endmodule

// ==== source/ternary_compare.sv ====
// Less-than and equal flags of two ternary words, scanned from the top trit down
`include "ternary_cfg.svh"

module ternary_compare (
    input  ternary_pkg::word_t a,
    input  ternary_pkg::word_t b,
    output logic               lt,
    output logic               eq
);
    import ternary_pkg::*;

    // Order is -1 < 0 < +1
    function automatic logic trit_lt(trit_t x, trit_t y);
        return ((x == TRIT_NEG) && (y != TRIT_NEG)) ||
               ((x == TRIT_ZERO) && (y == TRIT_POS));
    endfunction

    always_comb begin
        logic  lt_c;
        logic  eq_c;
        trit_t ta;
        trit_t tb;
        lt_c = 1'b0;
        eq_c = 1'b1;
        for (int i = `WORD_TRITS - 1; i >= 0; i--) begin
            ta = a[2*i +: 2];
            tb = b[2*i +: 2];
            // First differing trit from the top decides the order
            lt_c = lt_c | (eq_c & trit_lt(ta, tb));
            eq_c = eq_c & (ta == tb);
        end
        lt = lt_c;
        eq = eq_c;
    end

endmodule

// ==== source/alu_result.sv ====
// Result mux and output register of the ternary ALU, loads when the decoder asserts load
`include "ternary_cfg.svh"

module alu_result (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load,
    input  ternary_pkg::res_src_t res_src,
    input  ternary_pkg::word_t    a,
    input  ternary_pkg::word_t    logic_result,
    input  ternary_pkg::word_t    arith_result,
    input  logic                  lt,
    input  logic                  eq,
    output ternary_pkg::word_t    alu_out
);
    import ternary_pkg::*;

    word_t next_out;

    // Flag as +1 in trit 0, all other trits zero
    function automatic word_t flag_word(logic flag);
        return {{(`WORD_TRITS - 1){TRIT_ZERO}}, (flag ? TRIT_POS : TRIT_ZERO)};
    endfunction

    always_comb begin
        case (res_src)
            SRC_LOGIC: next_out = logic_result;
            SRC_ARITH: next_out = arith_result;
            SRC_LT:    next_out = flag_word(lt);
            SRC_EQ:    next_out = flag_word(eq);
            default:   next_out = a;
        endcase
    end

    // Holds its value while load is low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_out <= '0;
        end else if (load) begin
            alu_out <= next_out;
        end
    end

endmodule

// ==== source/ternary_alu_top.sv ====
// Top level of the 9-trit ternary ALU, one registered result per enabled clock
module ternary_alu_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 alu_enable,
    input  ternary_pkg::opcode_t opcode,
    input  ternary_pkg::word_t   a,
    input  ternary_pkg::word_t   b,
    output ternary_pkg::word_t   alu_out
);
    import ternary_pkg::*;

    logic_fn_t logic_fn;
    logic      sub;
    res_src_t  res_src;
    logic      load;
    word_t     logic_result;
    word_t     arith_result;
    logic      lt;
    logic      eq;

    alu_decode decode_i (
        .opcode     (opcode),
        .alu_enable (alu_enable),
        .logic_fn   (logic_fn),
        .sub        (sub),
        .res_src    (res_src),
        .load       (load)
    );

    trit_logic_unit logic_i (
        .a            (a),
        .b            (b),
        .logic_fn     (logic_fn),
        .logic_result (logic_result)
    );

    ternary_adder adder_i (
        .a            (a),
        .b            (b),
        .sub          (sub),
        .arith_result (arith_result)
    );

    ternary_compare compare_i (
        .a  (a),
        .b  (b),
        .lt (lt),
        .eq (eq)
    );

    alu_result result_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .load         (load),
        .res_src      (res_src),
        .a            (a),
        .logic_result (logic_result),
        .arith_result (arith_result),
        .lt           (lt),
        .eq           (eq),
        .alu_out      (alu_out)
    );

endmodule

// ==== test/ternary_alu_assert.sv ====
// Concurrent checks on the ALU output register, attached to alu_result by the bind below
`include "ternary_cfg.svh"

module ternary_alu_assert (
    input logic               clk,
    input logic               rst_n,
    input logic               load,
    input ternary_pkg::word_t alu_out
);
    timeunit 1ns;
    timeprecision 100ps;
    import ternary_pkg::*;

    // Code 10 is not a trit
    function automatic logic has_bad_trit(word_t w);
        logic bad;
        bad = 1'b0;
        for (int i = 0; i < `WORD_TRITS; i++) begin
            bad = bad | (w[2*i +: 2] == 2'b10);
        end
        return bad;
    endfunction

    reset_clears: assert property (@(posedge clk) !rst_n |-> alu_out == '0)
        else $error("alu_out is not zero while reset is asserted");

    hold_stable: assert property (@(posedge clk) disable iff (!rst_n) !load |=> $stable(alu_out))
        else $error("alu_out changed on an edge without load");

    valid_trits: assert property (@(posedge clk) disable iff (!rst_n) !has_bad_trit(alu_out))
        else $error("alu_out holds an invalid trit code");

endmodule

bind alu_result ternary_alu_assert assert_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .load    (load),
    .alu_out (alu_out)
);

// ==== test/ternary_alu_tb.sv ====
// Directed-test testbench of the ternary ALU, compiled from vlog.f as the simulation top
`include "ternary_cfg.svh"

module ternary_alu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import ternary_pkg::*;

    // About 400 cycles of tests, with margin
    localparam int TIMEOUT_CYCLES = 1500;
    localparam int WORD_RANGE = 3 ** `WORD_TRITS;
    localparam int WORD_MAX = (WORD_RANGE - 1) / 2;
    localparam word_t ALL_POS = {`WORD_TRITS{TRIT_POS}};
    localparam word_t ALL_NEG = {`WORD_TRITS{TRIT_NEG}};
    localparam word_t ONE = {{(`WORD_TRITS - 1){TRIT_ZERO}}, TRIT_POS};

    logic    clk;
    logic    rst_n;
    logic    alu_enable;
    opcode_t opcode;
    word_t   a;
    word_t   b;
    word_t   alu_out;
    integer  seed;
    int      cycles = 0;

    ternary_alu_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .alu_enable (alu_enable),
        .opcode     (opcode),
        .a          (a),
        .b          (b),
        .alu_out    (alu_out)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    function automatic int trit_val(trit_t t);
        case (t)
            TRIT_POS: return 1;
            TRIT_NEG: return -1;
            default:  return 0;
        endcase
    endfunction

    function automatic trit_t val_trit(int v);
        return (v > 0) ? TRIT_POS : (v < 0) ? TRIT_NEG : TRIT_ZERO;
    endfunction

    function automatic int to_int(word_t w);
        int s;
        s = 0;
        for (int i = `WORD_TRITS - 1; i >= 0; i--) begin
            s = s * 3 + trit_val(w[2*i +: 2]);
        end
        return s;
    endfunction

    function automatic word_t to_word(int v);
        word_t w;
        int    d;
        // Wrap into the balanced range first
        v = ((v + WORD_MAX) % WORD_RANGE + WORD_RANGE) % WORD_RANGE - WORD_MAX;
        for (int i = 0; i < `WORD_TRITS; i++) begin
            d = ((v % 3) + 3) % 3;
            if (d == 2) d = -1;
            w[2*i +: 2] = val_trit(d);
            v = (v - d) / 3;
        end
        return w;
    endfunction

    function automatic word_t logic_model(opcode_t op, word_t x, word_t y);
        word_t r;
        int    p;
        int    q;
        int    v;
        for (int i = 0; i < `WORD_TRITS; i++) begin
            p = trit_val(x[2*i +: 2]);
            q = trit_val(y[2*i +: 2]);
            case (op)
                OP_NOT:          v = -p;
                OP_AND, OP_ANDI: v = (p < q) ? p : q;
                OP_OR:           v = (p > q) ? p : q;
                default:         v = (p == 0) ? q : (q == 0) ? p : (p == -q) ? 0 : -1;
            endcase
            r[2*i +: 2] = val_trit(v);
        end
        return r;
    endfunction

    function automatic word_t rand_word();
        word_t w;
        int    r;
        for (int i = 0; i < `WORD_TRITS; i++) begin
            r = $unsigned($random(seed)) % 3;
            w[2*i +: 2] = val_trit(r - 1);
        end
        return w;
    endfunction

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_word(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_flag_word(string name, logic flag, word_t actual);
        word_t expected;
        expected = flag ? ONE : '0;
        if (actual !== expected) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    // Drive one operation, result is sampled 1 ns after the capturing edge
    task automatic apply_op(opcode_t op, word_t x, word_t y);
        opcode = op;
        a = x;
        b = y;
        alu_enable = 1'b1;
        @(posedge clk);
        #1;
    endtask

    task automatic test_logic_ops();
        opcode_t ops[4];
        word_t   x;
        word_t   y;
        ops = '{OP_NOT, OP_AND, OP_OR, OP_XOR};
        foreach (ops[k]) begin
            for (int i = 0; i < 40; i++) begin
                x = (i == 0) ? ALL_POS : (i == 1) ? ALL_NEG : rand_word();
                y = (i == 0) ? ALL_NEG : (i == 1) ? ALL_POS : rand_word();
                apply_op(ops[k], x, y);
                check_word("alu_out", logic_model(ops[k], x, y), alu_out);
            end
        end
    endtask

    task automatic test_add_sub();
        word_t x;
        word_t y;
        for (int i = 0; i < 40; i++) begin
            x = rand_word();
            y = rand_word();
            apply_op(OP_ADD, x, y);
            check_word("alu_out", to_word(to_int(x) + to_int(y)), alu_out);
            apply_op(OP_SUB, x, y);
            check_word("alu_out", to_word(to_int(x) - to_int(y)), alu_out);
        end
        // Wrap at both ends of the range
        apply_op(OP_ADD, ALL_POS, ONE);
        check_word("alu_out", ALL_NEG, alu_out);
        apply_op(OP_SUB, ALL_NEG, ONE);
        check_word("alu_out", ALL_POS, alu_out);
    endtask

    task automatic test_compare();
        word_t x;
        word_t y;
        for (int i = 0; i < 30; i++) begin
            x = rand_word();
            y = rand_word();
            if (i % 3 == 0) y = x;
            // Differ only in trit 0
            if (i % 3 == 1) begin
                y = x;
                y[1:0] = (x[1:0] == TRIT_POS) ? TRIT_NEG : TRIT_POS;
            end
            apply_op(OP_LT, x, y);
            check_flag_word("alu_out", to_int(x) < to_int(y), alu_out);
            apply_op(OP_EQ, x, y);
            check_flag_word("alu_out", x == y, alu_out);
        end
    endtask

    task automatic test_alias_pass();
        word_t x;
        word_t y;
        for (int i = 0; i < 10; i++) begin
            x = rand_word();
            y = rand_word();
            apply_op(OP_ANDI, x, y);
            check_word("alu_out", logic_model(OP_AND, x, y), alu_out);
            apply_op(OP_ADDI, x, y);
            check_word("alu_out", to_word(to_int(x) + to_int(y)), alu_out);
            apply_op(OP_COMP, x, y);
            check_word("alu_out", x, alu_out);
            apply_op(opcode_t'(6'b11_11_11), x, y);
            check_word("alu_out", x, alu_out);
        end
    endtask

    task automatic test_hold_reset();
        word_t held;
        word_t x;
        word_t y;
        x = rand_word();
        y = rand_word();
        held = to_word(to_int(x) - to_int(y));
        apply_op(OP_SUB, x, y);
        check_word("alu_out", held, alu_out);
        alu_enable = 1'b0;
        for (int i = 0; i < 6; i++) begin
            opcode = OP_ADD;
            a = rand_word();
            b = rand_word();
            @(posedge clk);
            #1;
            check_word("alu_out", held, alu_out);
        end
        // Reset wins over an enabled load
        rst_n = 1'b0;
        alu_enable = 1'b1;
        opcode = OP_COMP;
        a = ALL_POS;
        @(posedge clk);
        #1;
        check_word("alu_out", '0, alu_out);
        rst_n = 1'b1;
        apply_op(OP_COMP, ALL_POS, ALL_NEG);
        check_word("alu_out", ALL_POS, alu_out);
    endtask

    initial begin
        seed = 32'hc524_11c4;
        clk = 1'b0;
        rst_n = 1'b0;
        alu_enable = 1'b0;
        opcode = OP_NOT;
        a = '0;
        b = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_logic_ops();
        test_add_sub();
        test_compare();
        test_alias_pass();
        test_hold_reset();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+source
source/ternary_pkg.sv
source/alu_decode.sv
source/trit_logic_unit.sv
source/ternary_adder.sv
source/ternary_compare.sv
source/alu_result.sv
source/ternary_alu_top.sv
test/ternary_alu_assert.sv
test/ternary_alu_tb.sv
